//--- logic/obj_draw.sv
// Sprite draw engine, fetches ROM words and writes coloured pixels to the line buffer
`default_nettype none
`timescale 1ns/1ns

module obj_draw
    import obj_pkg::*, video_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cen2,
    input  logic          draw_start,
    input  obj_draw_req_t req,
    output logic          draw_busy,
    output logic [12:0]   rom_addr,
    output logic          rom_cs,
    input  logic [31:0]   rom_data,
    input  logic          rom_ok,
    input  logic [7:0]    prog_addr,
    input  logic [3:0]    prog_data,
    input  logic          prog_en,
    output buf_wr_t       wr
);

    obj_draw_state_t state;
    logic [2:0]      cnt;
    logic [31:0]     pxl_data;
    logic [7:0]      buf_a;
    logic [3:0]      prom [0:255];
    logic [3:0]      prom_q;
    logic            wr_we;
    logic [7:0]      wr_addr;
    logic            take_start;
    logic            word_ok;
    logic            shifting;

    // Undo the bit interleave of the graphics ROMs, pixel 0 ends up in the low nibble
    function automatic logic [31:0] unpack_word(input logic [31:0] d);
        logic [31:0] p;
        int          base;
        p = '0;
        for (int i = 0; i < 8; i++) begin
            base = (i / 4) * 16 + (i % 4);
            p[4 * i +: 4] = {d[base + 8], d[base + 12], d[base], d[base + 4]};
        end
        return p;
    endfunction

    assign take_start = state == DRAW_IDLE && draw_start;
    assign word_ok    = state == DRAW_REQ && rom_ok;
    assign shifting   = state == DRAW_SHIFT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= DRAW_IDLE;
            draw_busy <= 1'b0;
            rom_cs    <= 1'b0;
            cnt       <= '0;
            wr_we     <= 1'b0;
        end else if (cen2) begin
            case (state)
                DRAW_IDLE: begin
                    if (draw_start) begin
                        draw_busy <= 1'b1;
                        rom_cs    <= 1'b1;
                        state     <= DRAW_REQ;
                    end
                end
                // Wait as long as the ROM needs
                DRAW_REQ: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                        state  <= DRAW_SHIFT;
                    end
                end
                DRAW_SHIFT: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'd7) begin
                        if (!rom_addr[0]) begin
                            rom_cs <= 1'b1;
                            state  <= DRAW_REQ;
                        end else begin
                            state <= DRAW_DONE;
                        end
                    end
                end
                // Last pixel is in the buffer by now
                DRAW_DONE: begin
                    draw_busy <= 1'b0;
                    state     <= DRAW_IDLE;
                end
                default: state <= DRAW_IDLE;
            endcase
            wr_we <= shifting && pxl_data[3:0] != 4'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (cen2) begin
            if (take_start) begin
                rom_addr <= {req.code, req.row, 1'b0};
                buf_a    <= req.xpos + 8'(OBJ_X_OFFSET)
                            + (req.hflip ? 8'(OBJ_HFLIP_SPAN) : 8'd0);
            end
            if (word_ok) begin
                pxl_data <= unpack_word(rom_data);
            end
            if (shifting) begin
                pxl_data <= pxl_data >> 4;
                buf_a    <= req.hflip ? buf_a - 8'd1 : buf_a + 8'd1;
                wr_addr  <= buf_a;
                prom_q   <= prom[{req.pal, pxl_data[3:0]}];
                if (cnt == 3'd7) begin
                    rom_addr[0] <= 1'b1;
                end
            end
        end
    end

    // Colour PROM load port
    always_ff @(posedge clk) begin
        if (prog_en) begin
            prom[prog_addr] <= prog_data;
        end
    end

    assign wr = '{we: wr_we, addr: wr_addr, data: prom_q};

endmodule

`default_nettype wire

//--- logic/obj_engine.sv
// Sprite engine top level, ties sprite RAM, scanner, draw engine and line buffer together
`default_nettype none
`timescale 1ns/1ns

module obj_engine
    import obj_pkg::*, video_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  cpu_bus_t    cpu,
    output logic [7:0]  cpu_rdata,
    input  vid_timing_t timing,
    input  logic [7:0]  prog_addr,
    input  logic [3:0]  prog_data,
    input  logic        prog_en,
    output logic [12:0] rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic [3:0]  pxl
);

    logic          cen2;
    logic [5:0]    scan_addr;
    logic [7:0]    hi_q;
    logic [7:0]    lo_q;
    logic          draw_busy;
    logic          draw_start;
    obj_draw_req_t req;
    buf_wr_t       wr;

    // Scanner and draw engine step on every second clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen2 <= 1'b0;
        end else begin
            cen2 <= ~cen2;
        end
    end

    obj_ram ram_i (
        .clk       (clk),
        .cpu       (cpu),
        .cpu_rdata (cpu_rdata),
        .scan_addr (scan_addr),
        .hi_q      (hi_q),
        .lo_q      (lo_q)
    );

    obj_scan scan_i (
        .clk        (clk),
        .rst        (rst),
        .cen2       (cen2),
        .timing     (timing),
        .hi_q       (hi_q),
        .lo_q       (lo_q),
        .scan_addr  (scan_addr),
        .draw_busy  (draw_busy),
        .draw_start (draw_start),
        .req        (req)
    );

    obj_draw draw_i (
        .clk        (clk),
        .rst        (rst),
        .cen2       (cen2),
        .draw_start (draw_start),
        .req        (req),
        .draw_busy  (draw_busy),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_en    (prog_en),
        .wr         (wr)
    );

    obj_line_buffer line_buffer_i (
        .clk     (clk),
        .rst     (rst),
        .timing  (timing),
        .pxl_cen (pxl_cen),
        .wr      (wr),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

//--- logic/obj_line_buffer.sv
// Double line buffer, one half is drawn while the other is shown and erased
`default_nettype none
`timescale 1ns/1ns

module obj_line_buffer
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  vid_timing_t timing,
    input  logic        pxl_cen,
    input  buf_wr_t     wr,
    output logic [3:0]  pxl
);

    logic            half;
    logic [3:0]      mem [0:1][0:255];
    logic [1:0]      half_we;
    logic [1:0][7:0] half_addr;
    logic [1:0][3:0] half_data;
    logic            rd_clr;

    assign rd_clr = pxl_cen & timing.lhbl;

    // half is the side being drawn, the other side goes to the screen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half <= 1'b0;
        end else if (timing.hinit) begin
            half <= ~half;
        end
    end

    // One write port per half, shared by drawing and erasing
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            if (1'(b) == half) begin
                half_we[b]   = wr.we && wr.data != 4'd0;
                half_addr[b] = wr.addr;
                half_data[b] = wr.data;
            end else begin
                half_we[b]   = rd_clr;
                half_addr[b] = timing.hdump[7:0];
                half_data[b] = 4'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (half_we[b]) begin
                mem[b][half_addr[b]] <= half_data[b];
            end
        end
        // Old value is read out on the same edge that clears it
        pxl <= mem[~half][timing.hdump[7:0]];
    end

endmodule

`default_nettype wire

//--- logic/obj_pkg.sv
// Sprite engine constants, draw request and FSM state types, imported by scanner and draw engine
`default_nettype none

package obj_pkg;

    // Sprite table and board geometry
    localparam int OBJ_COUNT      = 24;
    localparam int OBJ_HEIGHT     = 16;
    localparam int OBJ_X_OFFSET   = 6;
    localparam int OBJ_HFLIP_SPAN = 15;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_POS_ATTR,
        SCAN_CODE_Y,
        SCAN_WAIT
    } obj_scan_state_t;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_REQ,
        DRAW_SHIFT,
        DRAW_DONE
    } obj_draw_state_t;

    // One sprite row handed from the scanner to the draw engine
    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
        logic [7:0] xpos;
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
    } obj_draw_req_t;

endpackage

`default_nettype wire

//--- logic/obj_ram.sv
// Sprite table RAM, two CPU banks with a read-only scan port each
`default_nettype none
`timescale 1ns/1ns

module obj_ram
    import video_pkg::*;
(
    input  logic       clk,
    input  cpu_bus_t   cpu,
    output logic [7:0] cpu_rdata,
    input  logic [5:0] scan_addr,
    output logic [7:0] hi_q,
    output logic [7:0] lo_q
);

    // Bank 0 is the lo bank (attribute, inverted Y), bank 1 the hi bank (X, code)
    logic [7:0]      mem [0:1][0:1023];
    logic [1:0]      bank_we;
    logic [1:0][7:0] cpu_q;
    logic [1:0][7:0] scan_q;

    assign bank_we = {cpu.cs_hi, cpu.cs_lo} & {2{~cpu.rnw}};

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (bank_we[b]) begin
                mem[b][cpu.addr] <= cpu.wdata;
            end
            cpu_q[b]  <= mem[b][cpu.addr];
            // Scanner only sees the first 64 bytes
            scan_q[b] <= mem[b][{4'd0, scan_addr}];
        end
    end

    // Lo bank wins when selected, hi bank otherwise
    assign cpu_rdata = cpu.cs_lo ? cpu_q[0] : cpu_q[1];

    assign lo_q = scan_q[0];
    assign hi_q = scan_q[1];

endmodule

`default_nettype wire

//--- logic/obj_scan.sv
// Sprite table scanner, picks the sprites on the next line and starts the draw engine
`default_nettype none
`timescale 1ns/1ns

module obj_scan
    import obj_pkg::*, video_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cen2,
    input  vid_timing_t   timing,
    input  logic [7:0]    hi_q,
    input  logic [7:0]    lo_q,
    output logic [5:0]    scan_addr,
    input  logic          draw_busy,
    output logic          draw_start,
    output obj_draw_req_t req
);

    obj_scan_state_t state;
    logic            hinit_x;
    logic [7:0]      ydiff;
    logic            in_zone;
    logic [3:0]      row;
    logic            last_entry;

    // Y is stored inverted in the lo bank
    assign ydiff      = timing.vrender - ~lo_q;
    assign in_zone    = ydiff < 8'(OBJ_HEIGHT);
    assign row        = (ydiff[3:0] - 4'd1) ^ {4{req.vflip}};
    assign last_entry = scan_addr[5:1] == 5'(OBJ_COUNT - 1);

    // Hold hinit until the next half-rate step sees it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hinit_x <= 1'b0;
        end else if (timing.hinit) begin
            hinit_x <= 1'b1;
        end else if (cen2) begin
            hinit_x <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= SCAN_IDLE;
            scan_addr  <= '0;
            draw_start <= 1'b0;
        end else if (cen2) begin
            draw_start <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    if (hinit_x) begin
                        scan_addr <= '0;
                        state     <= SCAN_POS_ATTR;
                    end
                end
                // Entry stays parked here while a sprite is being drawn
                SCAN_POS_ATTR: begin
                    if (!draw_busy) begin
                        scan_addr <= scan_addr + 6'd1;
                        state     <= SCAN_CODE_Y;
                    end
                end
                SCAN_CODE_Y: begin
                    scan_addr  <= scan_addr + 6'd1;
                    draw_start <= in_zone;
                    state      <= last_entry ? SCAN_IDLE : SCAN_WAIT;
                end
                // Lets draw_busy rise before the next entry
                SCAN_WAIT: state <= SCAN_POS_ATTR;
                default:   state <= SCAN_IDLE;
            endcase
        end
    end

    // Request fields, filled over the two read steps
    always_ff @(posedge clk) begin
        if (cen2) begin
            if (state == SCAN_POS_ATTR && !draw_busy) begin
                req.xpos  <= hi_q;
                req.pal   <= lo_q[3:0];
                req.hflip <= lo_q[6];
                req.vflip <= lo_q[7];
            end
            if (state == SCAN_CODE_Y) begin
                req.code <= hi_q;
                req.row  <= row;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/video_pkg.sv
// Video timing, CPU bus and line-buffer write types shared across the sprite engine
`default_nettype none

package video_pkg;

    typedef struct packed {
        logic       hinit;
        logic       lhbl;
        logic       lvbl;
        logic [7:0] vrender;
        logic [8:0] hdump;
    } vid_timing_t;

    typedef struct packed {
        logic [9:0] addr;
        logic [7:0] wdata;
        logic       cs_lo;
        logic       cs_hi;
        logic       rnw;
    } cpu_bus_t;

    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        logic [3:0] data;
    } buf_wr_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module obj_tb -f sources.f \
    && ./obj_dir/Vobj_tb > sim.log 2>&1 \
    || echo "Build or simulation stopped early"
cat sim.log 2>/dev/null
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log && exit 0 || exit 1

//--- sources.f
logic/obj_pkg.sv
logic/video_pkg.sv
logic/obj_ram.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_line_buffer.sv
logic/obj_engine.sv
verif/obj_clock_gen.sv
verif/obj_assertions.sv
verif/obj_tb.sv

//--- verif/obj_assertions.sv
// Protocol checks on the draw engine, bound into every obj_draw instance
`default_nettype none
`timescale 1ns/1ns

module obj_assertions (
    input logic clk,
    input logic rst,
    input logic draw_busy,
    input logic draw_start,
    input logic rom_cs,
    input logic rom_ok,
    input logic wr_we
);

    // ROM request is held until the ROM answers
    rom_cs_held: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs)
        else $error("rom_cs dropped before rom_ok");

    // Writes trail the pixels by one PROM step at most
    write_in_draw: assert property (@(posedge clk) disable iff (rst)
        wr_we |-> draw_busy || $past(draw_busy))
        else $error("line buffer write outside a sprite draw");

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        !(draw_start && draw_busy))
        else $error("draw_start while the draw engine is busy");

endmodule

bind obj_draw obj_assertions assertions_i (
    .clk        (clk),
    .rst        (rst),
    .draw_busy  (draw_busy),
    .draw_start (draw_start),
    .rom_cs     (rom_cs),
    .rom_ok     (rom_ok),
    .wr_we      (wr.we)
);

`default_nettype wire

//--- verif/obj_clock_gen.sv
// Testbench clock and reset source, 8 ns clock with reset held for three cycles
`default_nettype none
`timescale 1ns/1ns

module obj_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/obj_tb.sv
// Sprite engine testbench that applies a table of sprite images and checks each output line
`default_nettype none
`timescale 1ns/1ns

module obj_tb
    import obj_pkg::*, video_pkg::*;
();

    localparam int LINE_CLKS  = 1536;
    localparam int VIS_START  = 16;
    localparam int NROWS      = 6;
    localparam int LIMIT      = NROWS * LINE_CLKS * 3;
    localparam logic [7:0] EMPTY_LINE = 8'h60;
    localparam logic [7:0] FREE_Y     = 8'hE0;

    typedef struct packed {
        logic       on;
        logic [4:0] idx;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] code;
        logic [7:0] attr;
    } sprite_t;

    typedef struct packed {
        logic [7:0]       line;
        sprite_t [2:0]    spr;
    } row_t;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    cpu_bus_t    cpu;
    logic [7:0]  cpu_rdata;
    vid_timing_t timing;
    logic [7:0]  prog_addr;
    logic [3:0]  prog_data;
    logic        prog_en;
    logic [12:0] rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic [3:0]  pxl;

    row_t        rows [NROWS];
    logic [7:0]  ent_x [OBJ_COUNT];
    logic [7:0]  ent_y [OBJ_COUNT];
    logic [7:0]  ent_code [OBJ_COUNT];
    logic [7:0]  ent_attr [OBJ_COUNT];
    logic [3:0]  tgt_pix [256];
    logic [3:0]  show_pix [256];
    int          tgt_reqs;
    logic [31:0] lfsr;
    logic [1:0]  wait_cnt;
    logic        rom_busy;
    int          rom_reqs;
    int          cycles;

    obj_clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    obj_engine obj_engine_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .cpu       (cpu),
        .cpu_rdata (cpu_rdata),
        .timing    (timing),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pxl       (pxl)
    );

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    // Graphics ROM contents as a scrambled copy of the address
    function automatic logic [31:0] rom_word(input logic [12:0] a);
        logic [31:0] w;
        w = {19'd0, a} * 32'h9E37_79B1;
        return w ^ {a[6:0], a, a[11:0]};
    endfunction

    // Four bit planes per pixel spread over the word by the board's ROM wiring
    function automatic logic [3:0] pixel_at(input logic [31:0] w, input int i);
        int lsb;
        lsb = (i >= 4 ? 16 : 0) + (i & 3);
        return {w[lsb + 8], w[lsb + 12], w[lsb], w[lsb + 4]};
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic cpu_write(input logic hi, input logic [9:0] addr, input logic [7:0] data);
        cpu = '{addr: addr, wdata: data, cs_lo: !hi, cs_hi: hi, rnw: 1'b0};
        step();
        cpu = '{addr: addr, wdata: 8'd0, cs_lo: 1'b0, cs_hi: 1'b0, rnw: 1'b1};
    endtask

    task automatic cpu_read_check(input logic hi, input logic [9:0] addr, input logic [7:0] exp);
        cpu = '{addr: addr, wdata: 8'd0, cs_lo: !hi, cs_hi: hi, rnw: 1'b1};
        step();
        check(hi ? "cpu_rdata hi bank" : "cpu_rdata lo bank", 32'(cpu_rdata), 32'(exp));
        cpu.cs_lo = 1'b0;
        cpu.cs_hi = 1'b0;
    endtask

    task automatic add_sprite(input int r, input int s, input int idx, input logic [7:0] x,
                              input logic [7:0] y, input logic [7:0] code,
                              input logic [7:0] attr);
        rows[r].spr[s] = {1'b1, 5'(idx), x, y, code, attr};
    endtask

    task automatic fill_table();
        for (int r = 0; r < NROWS; r++) begin
            rows[r] = '0;
        end
        rows[0].line = 8'h25;
        add_sprite(0, 0, 0, 8'h40, 8'h20, 8'h12, 8'h03);
        rows[1].line = 8'h25;
        add_sprite(1, 0, 5, 8'h40, 8'h20, 8'h12, 8'h45);
        rows[2].line = 8'h2A;
        add_sprite(2, 0, 7, 8'h80, 8'h20, 8'h57, 8'h87);
        rows[3].line = 8'h21;
        add_sprite(3, 0, 23, 8'h10, 8'h21, 8'h6C, 8'hC9);
        // Two overlapping sprites and one that misses the line
        rows[4].line = 8'h34;
        add_sprite(4, 0, 2, 8'h50, 8'h30, 8'h21, 8'h02);
        add_sprite(4, 1, 9, 8'h58, 8'h2C, 8'h33, 8'h0B);
        add_sprite(4, 2, 15, 8'h20, 8'h90, 8'h44, 8'h05);
        // Wraps past the right edge of the buffer
        rows[5].line = 8'h1F;
        add_sprite(5, 0, 11, 8'hF0, 8'h10, 8'h7E, 8'h4E);
        add_sprite(5, 1, 12, 8'h30, 8'h40, 8'h99, 8'h01);
    endtask

    task automatic load_image(input row_t row);
        sprite_t s;
        for (int n = 0; n < OBJ_COUNT; n++) begin
            ent_x[n]    = 8'h00;
            ent_y[n]    = FREE_Y;
            ent_code[n] = 8'h00;
            ent_attr[n] = 8'h00;
        end
        for (int i = 0; i < 3; i++) begin
            s = row.spr[i];
            if (s.on) begin
                ent_x[s.idx]    = s.x;
                ent_y[s.idx]    = s.y;
                ent_code[s.idx] = s.code;
                ent_attr[s.idx] = s.attr;
            end
        end
        for (int n = 0; n < OBJ_COUNT; n++) begin
            cpu_write(1'b1, 10'(2 * n), ent_x[n]);
            cpu_write(1'b1, 10'(2 * n + 1), ent_code[n]);
            cpu_write(1'b0, 10'(2 * n), ent_attr[n]);
            cpu_write(1'b0, 10'(2 * n + 1), ~ent_y[n]);
        end
    endtask

    // Expected line with later entries drawn over earlier ones
    task automatic reference(input logic [7:0] line);
        logic [7:0]  diff;
        logic [3:0]  row;
        logic [31:0] w;
        logic [3:0]  pix;
        logic [3:0]  col;
        logic [7:0]  a;
        for (int i = 0; i < 256; i++) begin
            tgt_pix[i] = 4'd0;
        end
        tgt_reqs = 0;
        for (int n = 0; n < OBJ_COUNT; n++) begin
            diff = line - ent_y[n];
            if (diff < 8'(OBJ_HEIGHT)) begin
                tgt_reqs += 2;
                row = (diff[3:0] - 4'd1) ^ (ent_attr[n][7] ? 4'hF : 4'h0);
                for (int k = 0; k < 16; k++) begin
                    w   = rom_word({ent_code[n], row, 1'(k / 8)});
                    pix = pixel_at(w, k % 8);
                    col = pix ^ ent_attr[n][3:0];
                    if (ent_attr[n][6]) begin
                        a = 8'(int'(ent_x[n]) + OBJ_X_OFFSET + OBJ_HFLIP_SPAN - k);
                    end else begin
                        a = 8'(int'(ent_x[n]) + OBJ_X_OFFSET + k);
                    end
                    if (pix != 4'd0 && col != 4'd0) begin
                        tgt_pix[a] = col;
                    end
                end
            end
        end
    endtask

    // One video line that draws line vr and shows the previous one
    task automatic run_line(input logic [7:0] vr, input logic check_on, input int exp_reqs);
        logic [7:0] h;
        rom_reqs = 0;
        for (int c = 0; c < LINE_CLKS; c++) begin
            h = 8'((c - VIS_START) / 4);
            timing.hinit   = c == 0;
            timing.vrender = vr;
            timing.lhbl    = c >= VIS_START && c < VIS_START + 1024;
            timing.hdump   = timing.lhbl ? {1'b0, h} : 9'h100;
            pxl_cen        = (c % 4) == 0;
            // pxl holds the colour for one clock after hdump moves
            if (check_on && timing.lhbl && (c - VIS_START) % 4 == 1) begin
                check("pxl", 32'(pxl), 32'(show_pix[h]));
            end
            step();
        end
        if (check_on) begin
            check("rom requests", 32'(rom_reqs), 32'(exp_reqs));
        end
    endtask

    // ROM answers after 0 to 3 clocks
    always @(posedge clk) begin
        #1;
        if (!rom_cs) begin
            rom_busy = 1'b0;
            rom_ok   = 1'b0;
        end else begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_reqs++;
                wait_cnt = {lfsr_bit(), lfsr_bit()};
            end else if (wait_cnt != 2'd0) begin
                wait_cnt--;
            end
            rom_ok   = wait_cnt == 2'd0;
            rom_data = rom_word(rom_addr);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout, the run did not end within %0d cycles", LIMIT);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    initial begin
        cpu       = '{addr: 10'd0, wdata: 8'd0, cs_lo: 1'b0, cs_hi: 1'b0, rnw: 1'b1};
        timing    = '{hinit: 1'b0, lhbl: 1'b0, lvbl: 1'b1, vrender: 8'd0, hdump: 9'd0};
        pxl_cen   = 1'b0;
        prog_addr = 8'd0;
        prog_data = 4'd0;
        prog_en   = 1'b0;
        rom_data  = 32'd0;
        rom_ok    = 1'b0;
        lfsr      = 32'd75308;
        wait_cnt  = 2'd0;
        rom_busy  = 1'b0;
        rom_reqs  = 0;
        cycles    = 0;
        fill_table();
        wait (rst == 1'b0);
        step();

        cpu_write(1'b0, 10'h3F0, 8'hA5);
        cpu_write(1'b1, 10'h3F0, 8'h5A);
        cpu_read_check(1'b0, 10'h3F0, 8'hA5);
        cpu_read_check(1'b1, 10'h3F0, 8'h5A);

        // Colour is pixel XOR palette nibble
        for (int a = 0; a < 256; a++) begin
            prog_addr = 8'(a);
            prog_data = 4'(a >> 4) ^ 4'(a);
            prog_en   = 1'b1;
            step();
        end
        prog_en = 1'b0;

        // Blank table and two lines to clear both buffer halves
        load_image('0);
        run_line(EMPTY_LINE, 1'b0, 0);
        run_line(EMPTY_LINE, 1'b0, 0);

        for (int r = 0; r < NROWS; r++) begin
            load_image(rows[r]);
            reference(rows[r].line);
            for (int i = 0; i < 256; i++) begin
                show_pix[i] = 4'd0;
            end
            run_line(rows[r].line, 1'b1, tgt_reqs);
            show_pix = tgt_pix;
            run_line(EMPTY_LINE, 1'b1, 0);
        end

        // Two empty lines bring the last drawn half back to the screen
        for (int i = 0; i < 256; i++) begin
            show_pix[i] = 4'd0;
        end
        run_line(EMPTY_LINE, 1'b1, 0);
        run_line(EMPTY_LINE, 1'b1, 0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
